//--- x86_dec_pkg.sv
package x86_dec_pkg;

  // Instruction window and register file sizes
  localparam int unsigned win_bytes_lp = 12;
  localparam int unsigned win_bits_lp  = 8 * win_bytes_lp;
  localparam int unsigned reg_count_lp = 8;

  // Registers in x86 encoding order: eax, ecx, edx, ebx, esp, ebp, esi, edi
  typedef logic [reg_count_lp-1:0][31:0] gpr_file_t;

  // Reduced opcode class reported for each instruction
  typedef enum logic [2:0] {
    OPC_NOP     = 3'd0,
    OPC_ADD     = 3'd1,
    OPC_MOV     = 3'd2,
    OPC_INC     = 3'd3,
    OPC_IMUL    = 3'd4,
    OPC_INVALID = 3'd7
  } opc_e;

  // Operand form of the core opcode
  typedef enum logic [2:0] {
    // No operands at all
    FORM_NONE    = 3'd0,
    // ModR/M rm is the destination, reg is the source
    FORM_RM_R    = 3'd1,
    // ModR/M reg is the destination, rm is the source
    FORM_R_RM    = 3'd2,
    // Accumulator with a full-size immediate
    FORM_ACC_IMM = 3'd3,
    // ModR/M rm with a sign-extended imm8
    FORM_RM_IMM8 = 3'd4,
    // Register in the opcode low bits with a full-size immediate
    FORM_REG_IMM = 3'd5,
    // Register in the opcode low bits only
    FORM_REG     = 3'd6
  } form_e;

  // Kind of the single destination
  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_REG  = 2'd1,
    DEST_MEM  = 2'd2
  } dest_e;

  // Immediate size, IMM_FULL is 4 bytes or 2 bytes under 0x66
  typedef enum logic [1:0] {
    IMM_NONE = 2'd0,
    IMM_8    = 2'd1,
    IMM_FULL = 2'd2
  } imm_sz_e;

endpackage

//--- decode_prefix.sv
`timescale 1ns/1ps

module decode_prefix
  import x86_dec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_req,
  output logic                   in_ack,
  input  logic [win_bits_lp-1:0] raw_instr,
  input  logic                   s2_free,
  output logic                   s1_valid,
  output logic [win_bits_lp-1:0] s1_bytes,
  output logic                   s1_op16,
  output logic [1:0]             s1_prefix_count
);

  logic [win_bytes_lp-1:0][7:0] win;
  logic [1:0]                   pfx_count;
  logic                         capture;

  assign win = raw_instr;

  // Count up to two leading operand-size prefixes. A third 0x66 stays in
  // the window and is rejected as an unknown opcode in stage 2
  always_comb begin
    if (win[0] == 8'h66 && win[1] == 8'h66) begin
      pfx_count = 2'd2;
    end else if (win[0] == 8'h66) begin
      pfx_count = 2'd1;
    end else begin
      pfx_count = 2'd0;
    end
  end

  // New request, not yet acknowledged, and stage 1 is or becomes free
  assign capture = in_req && !in_ack && s2_free;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_ack   <= 1'b0;
      s1_valid <= 1'b0;
    end else begin
      if (capture) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;
      end
      // When stage 1 is free its content moves on, so only a capture keeps it valid
      if (s2_free) begin
        s1_valid <= capture;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      s1_bytes        <= raw_instr >> {pfx_count, 3'b000};
      s1_op16         <= (pfx_count != 2'd0);
      s1_prefix_count <= pfx_count;
    end
  end

endmodule

//--- decode_opcode.sv
`timescale 1ns/1ps

module decode_opcode
  import x86_dec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   s1_valid,
  input  logic [win_bits_lp-1:0] s1_bytes,
  input  logic                   s1_op16,
  input  logic [1:0]             s1_prefix_count,
  output logic                   s2_free,
  input  logic                   s3_free,
  output logic                   s2_valid,
  output logic [win_bits_lp-1:0] s2_bytes,
  output logic                   s2_is_2byte,
  output logic                   s2_op16,
  output logic [1:0]             s2_prefix_count,
  output opc_e                   s2_opc,
  output form_e                  s2_form,
  output imm_sz_e                s2_imm_sz,
  output logic                   s2_invalid
);

  logic                   is_esc;
  logic [win_bits_lp-1:0] unescaped;
  logic [7:0]             core_op;
  logic [2:0]             modrm_reg;
  logic                   s2_take;
  logic                   s2_ready;
  opc_e                   opc_d;
  form_e                  form_d;
  imm_sz_e                imm_d;

  assign is_esc    = (s1_bytes[7:0] == 8'h0f);
  assign unescaped = is_esc ? (s1_bytes >> 8) : s1_bytes;
  assign core_op   = unescaped[7:0];
  assign modrm_reg = unescaped[13:11];

  // Opcode table. Prefix bytes 67, F2, F3 and all unlisted opcodes fall to default
  always_comb begin
    opc_d  = OPC_INVALID;
    form_d = FORM_NONE;
    imm_d  = IMM_NONE;
    if (is_esc) begin
      // Only IMUL r32, r/m32 is supported behind the escape
      if (core_op == 8'haf) begin
        opc_d  = OPC_IMUL;
        form_d = FORM_R_RM;
      end
    end else begin
      case (core_op) inside
        8'h01: begin opc_d = OPC_ADD; form_d = FORM_RM_R; end
        8'h03: begin opc_d = OPC_ADD; form_d = FORM_R_RM; end
        8'h05: begin opc_d = OPC_ADD; form_d = FORM_ACC_IMM; imm_d = IMM_FULL; end
        8'h83: begin
          // Group 1, only /0 (ADD) is decoded
          if (modrm_reg == 3'd0) begin
            opc_d  = OPC_ADD;
            form_d = FORM_RM_IMM8;
            imm_d  = IMM_8;
          end
        end
        8'h89: begin opc_d = OPC_MOV; form_d = FORM_RM_R; end
        8'h8b: begin opc_d = OPC_MOV; form_d = FORM_R_RM; end
        [8'h40:8'h47]: begin opc_d = OPC_INC; form_d = FORM_REG; end
        [8'hb8:8'hbf]: begin opc_d = OPC_MOV; form_d = FORM_REG_IMM; imm_d = IMM_FULL; end
        8'h90: begin opc_d = OPC_NOP; form_d = FORM_NONE; end
        default: ;
      endcase
    end
  end

  // Stage 2 hands over when stage 3 accepts, and loads when empty or handing over
  assign s2_take  = s2_valid && s3_free;
  assign s2_ready = !s2_valid || s2_take;
  assign s2_free  = !s1_valid || s2_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else if (s2_ready) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_ready && s1_valid) begin
      s2_bytes        <= unescaped;
      s2_is_2byte     <= is_esc;
      s2_op16         <= s1_op16;
      s2_prefix_count <= s1_prefix_count;
      s2_opc          <= opc_d;
      s2_form         <= form_d;
      s2_imm_sz       <= imm_d;
      s2_invalid      <= (opc_d == OPC_INVALID);
    end
  end

endmodule

//--- decode_opnds.sv
`timescale 1ns/1ps

module decode_opnds
  import x86_dec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   s2_valid,
  input  logic [win_bits_lp-1:0] s2_bytes,
  input  logic                   s2_is_2byte,
  input  logic                   s2_op16,
  input  logic [1:0]             s2_prefix_count,
  input  opc_e                   s2_opc,
  input  form_e                  s2_form,
  input  imm_sz_e                s2_imm_sz,
  input  logic                   s2_invalid,
  input  gpr_file_t              gpr,
  output logic                   s3_free,
  output logic                   out_req,
  input  logic                   out_ack,
  output logic [3:0]             instr_len,
  output opc_e                   opc,
  output logic [31:0]            opnd0_r,
  output logic [31:0]            opnd1_r,
  output logic                   src_mem,
  output dest_e                  dest_kind,
  output logic [31:0]            dest_sel
);

  logic                   has_modrm;
  logic [1:0]             mod_f;
  logic [2:0]             reg_f;
  logic [2:0]             rm_f;
  logic [2:0]             op_reg;
  logic                   rm_is_mem;
  logic                   bad;
  logic [3:0]             disp_len;
  logic [3:0]             imm_len;
  logic [2:0]             imm_pos;
  logic [31:0]            disp;
  logic [31:0]            eff_addr;
  logic [win_bits_lp-1:0] imm_win;
  logic [31:0]            imm;
  logic [31:0]            width_mask;
  logic [31:0]            reg_val;
  logic [31:0]            rm_val;
  logic [31:0]            op_val;
  logic [31:0]            eax_val;
  logic [3:0]             len_d;
  logic [31:0]            opnd0_d;
  logic [31:0]            opnd1_d;
  logic                   src_mem_d;
  dest_e                  dest_kind_d;
  logic [31:0]            dest_sel_d;

  assign has_modrm = (s2_form == FORM_RM_R) || (s2_form == FORM_R_RM) ||
                     (s2_form == FORM_RM_IMM8);
  assign mod_f     = s2_bytes[15:14];
  assign reg_f     = s2_bytes[13:11];
  assign rm_f      = s2_bytes[10:8];
  assign op_reg    = s2_bytes[2:0];
  assign rm_is_mem = has_modrm && (mod_f != 2'd3);

  // SIB and absolute disp32 addressing are outside the decoded subset
  assign bad = s2_invalid || (rm_is_mem && rm_f == 3'd4) ||
               (rm_is_mem && mod_f == 2'd0 && rm_f == 3'd5);

  assign disp_len = !rm_is_mem    ? 4'd0 :
                    (mod_f == 2'd1) ? 4'd1 :
                    (mod_f == 2'd2) ? 4'd4 : 4'd0;
  assign disp     = (disp_len == 4'd1) ? {{24{s2_bytes[23]}}, s2_bytes[23:16]} :
                    (disp_len == 4'd4) ? s2_bytes[47:16] : 32'd0;
  assign eff_addr = gpr[rm_f] + disp;

  // The immediate follows the opcode, ModR/M and displacement
  assign imm_pos = 3'd1 + {2'd0, has_modrm} + disp_len[2:0];
  assign imm_win = s2_bytes >> {imm_pos, 3'b000};
  assign imm_len = (s2_imm_sz == IMM_8)    ? 4'd1 :
                   (s2_imm_sz == IMM_FULL) ? (s2_op16 ? 4'd2 : 4'd4) : 4'd0;

  // Under 0x66 register values and immediates are zero-extended from 16 bits
  assign width_mask = s2_op16 ? 32'h0000_ffff : 32'hffff_ffff;
  assign imm        = ((s2_imm_sz == IMM_8) ? {{24{imm_win[7]}}, imm_win[7:0]} :
                       imm_win[31:0]) & width_mask;
  assign reg_val    = gpr[reg_f] & width_mask;
  assign rm_val     = gpr[rm_f] & width_mask;
  assign op_val     = gpr[op_reg] & width_mask;
  assign eax_val    = gpr[0] & width_mask;

  assign len_d = {2'd0, s2_prefix_count} + (s2_is_2byte ? 4'd2 : 4'd1) +
                 {3'd0, has_modrm} + disp_len + imm_len;

  always_comb begin
    opnd0_d     = 32'd0;
    opnd1_d     = 32'd0;
    src_mem_d   = 1'b0;
    dest_kind_d = DEST_REG;
    dest_sel_d  = 32'd0;
    case (s2_form)
      FORM_RM_R, FORM_RM_IMM8: begin
        opnd0_d     = rm_is_mem ? eff_addr : rm_val;
        opnd1_d     = (s2_form == FORM_RM_R) ? reg_val : imm;
        dest_kind_d = rm_is_mem ? DEST_MEM : DEST_REG;
        dest_sel_d  = rm_is_mem ? eff_addr : {29'd0, rm_f};
      end
      FORM_R_RM: begin
        opnd0_d    = reg_val;
        opnd1_d    = rm_is_mem ? eff_addr : rm_val;
        src_mem_d  = rm_is_mem;
        dest_sel_d = {29'd0, reg_f};
      end
      FORM_ACC_IMM: begin
        opnd0_d = eax_val;
        opnd1_d = imm;
      end
      FORM_REG_IMM, FORM_REG: begin
        opnd0_d    = op_val;
        opnd1_d    = (s2_form == FORM_REG_IMM) ? imm : 32'd0;
        dest_sel_d = {29'd0, op_reg};
      end
      default: dest_kind_d = DEST_NONE;
    endcase
  end

  // A retired result lowers out_req, and a new one waits for out_ack low
  assign s3_free = !out_req && !out_ack;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_req <= 1'b0;
    end else if (out_req && out_ack) begin
      out_req <= 1'b0;
    end else if (s3_free && s2_valid) begin
      out_req <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (s3_free && s2_valid) begin
      instr_len <= bad ? 4'd0 : len_d;
      opc       <= bad ? OPC_INVALID : s2_opc;
      opnd0_r   <= bad ? 32'd0 : opnd0_d;
      opnd1_r   <= bad ? 32'd0 : opnd1_d;
      src_mem   <= bad ? 1'b0 : src_mem_d;
      dest_kind <= bad ? DEST_NONE : dest_kind_d;
      dest_sel  <= bad ? 32'd0 : dest_sel_d;
    end
  end

endmodule

//--- decode.sv
`timescale 1ns/1ps

module decode
  import x86_dec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_req,
  output logic                   in_ack,
  input  logic [win_bits_lp-1:0] raw_instr,
  input  gpr_file_t              gpr,
  output logic                   out_req,
  input  logic                   out_ack,
  output logic [3:0]             instr_len,
  output opc_e                   opc,
  output logic [31:0]            opnd0_r,
  output logic [31:0]            opnd1_r,
  output logic                   src_mem,
  output dest_e                  dest_kind,
  output logic [31:0]            dest_sel
);

  // Stage 1 to stage 2
  logic                   s1_valid;
  logic [win_bits_lp-1:0] s1_bytes;
  logic                   s1_op16;
  logic [1:0]             s1_prefix_count;
  logic                   s2_free;

  // Stage 2 to stage 3
  logic                   s2_valid;
  logic [win_bits_lp-1:0] s2_bytes;
  logic                   s2_is_2byte;
  logic                   s2_op16;
  logic [1:0]             s2_prefix_count;
  opc_e                   s2_opc;
  form_e                  s2_form;
  imm_sz_e                s2_imm_sz;
  logic                   s2_invalid;
  logic                   s3_free;

  // Prefix stripping and the input handshake
  decode_prefix prefix_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_req          (in_req),
    .in_ack          (in_ack),
    .raw_instr       (raw_instr),
    .s2_free         (s2_free),
    .s1_valid        (s1_valid),
    .s1_bytes        (s1_bytes),
    .s1_op16         (s1_op16),
    .s1_prefix_count (s1_prefix_count)
  );

  // Escape detection and opcode classification
  decode_opcode opcode_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .s1_valid        (s1_valid),
    .s1_bytes        (s1_bytes),
    .s1_op16         (s1_op16),
    .s1_prefix_count (s1_prefix_count),
    .s2_free         (s2_free),
    .s3_free         (s3_free),
    .s2_valid        (s2_valid),
    .s2_bytes        (s2_bytes),
    .s2_is_2byte     (s2_is_2byte),
    .s2_op16         (s2_op16),
    .s2_prefix_count (s2_prefix_count),
    .s2_opc          (s2_opc),
    .s2_form         (s2_form),
    .s2_imm_sz       (s2_imm_sz),
    .s2_invalid      (s2_invalid)
  );

  // Operand formation and the output handshake
  decode_opnds opnds_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .s2_valid        (s2_valid),
    .s2_bytes        (s2_bytes),
    .s2_is_2byte     (s2_is_2byte),
    .s2_op16         (s2_op16),
    .s2_prefix_count (s2_prefix_count),
    .s2_opc          (s2_opc),
    .s2_form         (s2_form),
    .s2_imm_sz       (s2_imm_sz),
    .s2_invalid      (s2_invalid),
    .gpr             (gpr),
    .s3_free         (s3_free),
    .out_req         (out_req),
    .out_ack         (out_ack),
    .instr_len       (instr_len),
    .opc             (opc),
    .opnd0_r         (opnd0_r),
    .opnd1_r         (opnd1_r),
    .src_mem         (src_mem),
    .dest_kind       (dest_kind),
    .dest_sel        (dest_sel)
  );

endmodule

//--- decode_checker.sv
`timescale 1ns/1ps

module decode_checker
  import x86_dec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_req,
  input  logic                   in_ack,
  input  logic [win_bits_lp-1:0] raw_instr,
  input  gpr_file_t              gpr,
  input  logic                   out_req,
  input  logic                   out_ack,
  input  logic [3:0]             instr_len,
  input  opc_e                   opc,
  input  logic [31:0]            opnd0_r,
  input  logic [31:0]            opnd1_r,
  input  logic                   src_mem,
  input  dest_e                  dest_kind,
  input  logic [31:0]            dest_sel,
  output int                     error_count,
  output int                     result_count,
  output int                     pending
);

  // Accepted windows and register snapshots with the oldest first
  logic [win_bits_lp-1:0] win_q [$];
  gpr_file_t              gpr_q [$];
  logic                   prev_ack;
  logic                   prev_req;
  logic                   rst_seen;
  logic                   rst_checked;
  logic [win_bits_lp-1:0] w;
  gpr_file_t              g;
  logic [3:0]             e_len;
  opc_e                   e_opc;
  logic [31:0]            e_op0;
  logic [31:0]            e_op1;
  logic                   e_sm;
  dest_e                  e_dk;
  logic [31:0]            e_ds;

  initial begin
    error_count  = 0;
    result_count = 0;
    pending      = 0;
    prev_ack     = 1'b0;
    prev_req     = 1'b0;
    rst_seen     = 1'b0;
    rst_checked  = 1'b0;
  end

  task automatic report_error(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %0t ns %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
      error_count++;
    end
  endtask

  // Walks the window byte by byte through prefixes, opcode, ModR/M, displacement and immediate
  function automatic void decode_ref(
    input  logic [win_bits_lp-1:0] win,
    input  gpr_file_t              regs,
    output logic [3:0]             len,
    output opc_e                   op,
    output logic [31:0]            o0,
    output logic [31:0]            o1,
    output logic                   sm,
    output dest_e                  dk,
    output logic [31:0]            ds
  );
    logic [7:0]  b [0:11];
    int          pos;
    logic        op16;
    logic [31:0] mask;
    logic [7:0]  code;
    logic        ok;
    logic        imm8;
    logic        immf;
    form_e       f;
    logic [1:0]  md;
    logic [2:0]  rg;
    logic [2:0]  rm;
    logic        mem;
    logic [31:0] ea;
    logic [31:0] disp;
    logic [31:0] imm;
    for (int i = 0; i < 12; i++) begin
      b[i] = win[8*i +: 8];
    end
    pos  = 0;
    op16 = 1'b0;
    while (pos < 2 && b[pos] == 8'h66) begin
      pos++;
      op16 = 1'b1;
    end
    mask = op16 ? 32'h0000_ffff : 32'hffff_ffff;
    ok   = 1'b1;
    op   = OPC_INVALID;
    f    = FORM_NONE;
    imm8 = 1'b0;
    immf = 1'b0;
    code = b[pos];
    pos++;
    if (code == 8'h0f) begin
      if (b[pos] == 8'haf) begin
        op = OPC_IMUL;
        f  = FORM_R_RM;
      end else begin
        ok = 1'b0;
      end
      pos++;
    end else if (code == 8'h01 || code == 8'h89) begin
      op = (code == 8'h01) ? OPC_ADD : OPC_MOV;
      f  = FORM_RM_R;
    end else if (code == 8'h03 || code == 8'h8b) begin
      op = (code == 8'h03) ? OPC_ADD : OPC_MOV;
      f  = FORM_R_RM;
    end else if (code == 8'h05) begin
      op   = OPC_ADD;
      f    = FORM_ACC_IMM;
      immf = 1'b1;
    end else if (code == 8'h83 && b[pos][5:3] == 3'd0) begin
      op   = OPC_ADD;
      f    = FORM_RM_IMM8;
      imm8 = 1'b1;
    end else if (code[7:3] == 5'b01000) begin
      op = OPC_INC;
      f  = FORM_REG;
    end else if (code[7:3] == 5'b10111) begin
      op   = OPC_MOV;
      f    = FORM_REG_IMM;
      immf = 1'b1;
    end else if (code == 8'h90) begin
      op = OPC_NOP;
    end else begin
      ok = 1'b0;
    end
    mem = 1'b0;
    ea  = 32'd0;
    rg  = 3'd0;
    rm  = 3'd0;
    if (ok && (f == FORM_RM_R || f == FORM_R_RM || f == FORM_RM_IMM8)) begin
      md  = b[pos][7:6];
      rg  = b[pos][5:3];
      rm  = b[pos][2:0];
      pos++;
      mem = (md != 2'd3);
      if (mem && rm == 3'd4) ok = 1'b0;
      if (md == 2'd0 && rm == 3'd5) ok = 1'b0;
      disp = 32'd0;
      if (md == 2'd1) begin
        disp = {{24{b[pos][7]}}, b[pos]};
        pos += 1;
      end else if (md == 2'd2) begin
        disp = {b[pos+3], b[pos+2], b[pos+1], b[pos]};
        pos += 4;
      end
      ea = regs[rm] + disp;
    end
    imm = 32'd0;
    if (imm8) begin
      imm = {{24{b[pos][7]}}, b[pos]} & mask;
      pos += 1;
    end else if (immf && op16) begin
      imm = {16'd0, b[pos+1], b[pos]};
      pos += 2;
    end else if (immf) begin
      imm = {b[pos+3], b[pos+2], b[pos+1], b[pos]};
      pos += 4;
    end
    len = 4'd0;
    o0  = 32'd0;
    o1  = 32'd0;
    sm  = 1'b0;
    dk  = DEST_NONE;
    ds  = 32'd0;
    if (!ok) begin
      op = OPC_INVALID;
    end else begin
      len = 4'(pos);
      case (f)
        FORM_RM_R, FORM_RM_IMM8: begin
          o0 = mem ? ea : (regs[rm] & mask);
          o1 = (f == FORM_RM_R) ? (regs[rg] & mask) : imm;
          dk = mem ? DEST_MEM : DEST_REG;
          ds = mem ? ea : {29'd0, rm};
        end
        FORM_R_RM: begin
          o0 = regs[rg] & mask;
          o1 = mem ? ea : (regs[rm] & mask);
          sm = mem;
          dk = DEST_REG;
          ds = {29'd0, rg};
        end
        FORM_ACC_IMM: begin
          o0 = regs[0] & mask;
          o1 = imm;
          dk = DEST_REG;
        end
        FORM_REG_IMM, FORM_REG: begin
          o0 = regs[code[2:0]] & mask;
          o1 = (f == FORM_REG_IMM) ? imm : 32'd0;
          dk = DEST_REG;
          ds = {29'd0, code[2:0]};
        end
        default: ;
      endcase
    end
  endfunction

  // Inputs are held around the capture edge and outputs while out_req is high,
  // so the falling edge is a stable place to look
  always @(negedge clk) begin
    if (!rst_n) begin
      rst_seen = 1'b1;
      prev_ack = 1'b0;
      prev_req = 1'b0;
    end else begin
      if (rst_seen && !rst_checked) begin
        rst_checked = 1'b1;
        if (in_ack !== 1'b0 || out_req !== 1'b0) begin
          report_error("in_ack or out_req did not return low after reset");
        end
      end
      if (in_ack === 1'b1 && prev_ack !== 1'b1) begin
        // A capture edge needs in_req high in the cycle before it
        if (prev_req !== 1'b1) begin
          report_error("in_ack rose without a pending request");
        end
        if (win_q.size() >= 3) begin
          report_error("More than three instructions accepted while results were held");
        end
        win_q.push_back(raw_instr);
        gpr_q.push_back(gpr);
      end
      prev_ack = in_ack;
      prev_req = in_req;
      if (out_req === 1'b1 && out_ack === 1'b1) begin
        if (win_q.size() == 0) begin
          report_error("Result handshake with no pending input");
        end else begin
          w = win_q.pop_front();
          g = gpr_q.pop_front();
          decode_ref(w, g, e_len, e_opc, e_op0, e_op1, e_sm, e_dk, e_ds);
          check_field("instr_len", {28'd0, e_len}, {28'd0, instr_len});
          check_field("opc", {29'd0, e_opc}, {29'd0, opc});
          check_field("opnd0_r", e_op0, opnd0_r);
          check_field("opnd1_r", e_op1, opnd1_r);
          check_field("src_mem", {31'd0, e_sm}, {31'd0, src_mem});
          check_field("dest_kind", {30'd0, e_dk}, {30'd0, dest_kind});
          check_field("dest_sel", e_ds, dest_sel);
        end
        result_count++;
      end
      pending = win_q.size();
    end
  end

endmodule

//--- tb_decode.sv
`timescale 1ns/1ps

module tb_decode
  import x86_dec_pkg::*;
;

  // 32 + 18 + 24 + 13 + 6 + 200 instructions over the six tests
  localparam int total_instr_lp    = 293;
  localparam int timeout_cycles_lp = 40 * total_instr_lp + 200;

  logic                   clk;
  logic                   rst_n;
  logic                   in_req;
  logic                   in_ack;
  logic [win_bits_lp-1:0] raw_instr;
  gpr_file_t              gpr;
  logic                   out_req;
  logic                   out_ack;
  logic [3:0]             instr_len;
  opc_e                   opc;
  logic [31:0]            opnd0_r;
  logic [31:0]            opnd1_r;
  logic                   src_mem;
  dest_e                  dest_kind;
  logic [31:0]            dest_sel;
  int                     error_count;
  int                     result_count;
  int                     pending;

  logic [31:0]            lcg_state;
  logic [win_bits_lp-1:0] win_buf;
  int                     win_len;
  int                     ack_delay;
  logic                   random_ack;
  int                     pass_tests;
  int                     fail_tests;
  int                     err_mark;
  int                     res_mark;

  decode dut_i (.*);

  decode_checker chk_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int pick(input int n);
    return int'((lcg_next() >> 16) % n);
  endfunction

  function automatic logic [7:0] rand_byte();
    return 8'(lcg_next() >> 24);
  endfunction

  function automatic logic [7:0] alu_op(input int k);
    case (k)
      0:       return 8'h01;
      1:       return 8'h03;
      2:       return 8'h89;
      default: return 8'h8b;
    endcase
  endfunction

  task automatic add_byte(input logic [7:0] v);
    win_buf[win_len*8 +: 8] = v;
    win_len++;
  endtask

  // Little-endian, lowest byte first
  task automatic add_word(input logic [31:0] v, input int n);
    for (int i = 0; i < n; i++) begin
      add_byte(v[8*i +: 8]);
    end
  endtask

  task automatic add_prefixes(input int n);
    repeat (n) add_byte(8'h66);
  endtask

  // A negative mod picks one at random; SIB and absolute disp32 are steered away
  task automatic add_modrm(input logic [2:0] rg, input int mod);
    int         md;
    logic [2:0] rm;
    md = (mod < 0) ? pick(4) : mod;
    rm = 3'(pick(8));
    if (md != 3 && rm == 3'd4) rm = 3'd3;
    if (md == 0 && rm == 3'd5) rm = 3'd6;
    add_byte({2'(md), rg, rm});
    if (md == 1) add_byte(rand_byte());
    if (md == 2) add_word(lcg_next(), 4);
  endtask

  // Fills the rest of the window and runs one four-phase input handshake
  task automatic send_instr();
    while (win_len < win_bytes_lp) add_byte(rand_byte());
    @(posedge clk);
    #1;
    raw_instr = win_buf;
    in_req    = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!in_ack);
    in_req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (in_ack);
    win_len = 0;
  endtask

  task automatic send_bytes(input logic [31:0] v, input int n);
    add_word(v, n);
    send_instr();
  endtask

  task automatic add_invalid();
    logic [7:0] b;
    case (pick(5))
      0: begin
        add_byte(8'h8b);
        add_byte({2'(pick(3)), 3'(pick(8)), 3'd4});
      end
      1: begin
        add_byte(8'h8b);
        add_byte({2'd0, 3'(pick(8)), 3'd5});
      end
      2: begin
        b = rand_byte();
        if (b == 8'haf) b = 8'h01;
        add_byte(8'h0f);
        add_byte(b);
      end
      3: begin
        add_byte(8'h83);
        add_modrm(3'(1 + pick(7)), -1);
        add_byte(rand_byte());
      end
      default: add_word(32'h00c1_8b67, 3);
    endcase
  endtask

  task automatic send_random();
    int pc;
    pc = pick(3);
    add_prefixes(pc);
    case (pick(8))
      0: begin
        add_byte(alu_op(pick(4)));
        add_modrm(3'(pick(8)), 3);
      end
      1: begin
        add_byte(8'h05);
        add_word(lcg_next(), (pc > 0) ? 2 : 4);
      end
      2: begin
        add_byte(8'(8'hb8 + pick(8)));
        add_word(lcg_next(), (pc > 0) ? 2 : 4);
      end
      3: begin
        add_byte(8'h83);
        add_modrm(3'd0, -1);
        add_byte(rand_byte());
      end
      4: begin
        add_byte(alu_op(pick(4)));
        add_modrm(3'(pick(8)), pick(3));
      end
      5: begin
        add_word(32'haf0f, 2);
        add_modrm(3'(pick(8)), -1);
      end
      6: add_byte((pick(2) == 0) ? 8'h90 : 8'(8'h40 + pick(8)));
      default: add_invalid();
    endcase
    send_instr();
  endtask

  task automatic randomize_gpr();
    for (int i = 0; i < reg_count_lp; i++) begin
      gpr[i] = lcg_next();
    end
  endtask

  // The register file may only change once nothing is in flight
  task automatic wait_idle();
    while (pending != 0 || out_req || out_ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic close_test(input string name);
    int errs;
    int res;
    wait_idle();
    errs = error_count - err_mark;
    res  = result_count - res_mark;
    if (errs == 0) begin
      pass_tests++;
      $display("PASS %s: %0d results checked", name, res);
    end else begin
      fail_tests++;
      $display("FAIL %s: %0d errors in %0d results", name, errs, res);
    end
    err_mark = error_count;
    res_mark = result_count;
  endtask

  // Output side of the handshake, acknowledging each result after a delay
  initial begin
    int d;
    out_ack = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (out_req) begin
        d = random_ack ? pick(6) : ack_delay;
        repeat (d) @(posedge clk);
        if (d > 0) #1;
        out_ack = 1'b1;
        do begin
          @(posedge clk);
          #1;
        end while (out_req);
        out_ack = 1'b0;
      end
    end
  end

  initial begin
    repeat (timeout_cycles_lp) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    lcg_state  = 32'h873f_dfaa;
    rst_n      = 1'b0;
    in_req     = 1'b0;
    raw_instr  = '0;
    gpr        = '0;
    win_buf    = '0;
    win_len    = 0;
    ack_delay  = 1;
    random_ack = 1'b0;
    pass_tests = 0;
    fail_tests = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n    = 1'b1;
    err_mark = error_count;
    res_mark = result_count;

    randomize_gpr();
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 4; k++) begin
        add_byte(alu_op(k));
        add_byte({2'b11, 3'(7 - i), 3'(i)});
        send_instr();
      end
    end
    close_test("register forms");

    randomize_gpr();
    for (int pc = 0; pc < 3; pc++) begin
      for (int rep = 0; rep < 2; rep++) begin
        add_prefixes(pc);
        add_byte(8'h05);
        add_word(lcg_next() | 32'h8000_8000, (pc > 0) ? 2 : 4);
        send_instr();
        add_prefixes(pc);
        add_byte(8'(8'hb8 + pick(8)));
        add_word(lcg_next() | 32'h8000_8000, (pc > 0) ? 2 : 4);
        send_instr();
        add_prefixes(pc);
        add_byte(8'h83);
        add_modrm(3'd0, 3);
        add_byte(rand_byte() | 8'h80);
        send_instr();
      end
    end
    close_test("immediates and prefixes");

    randomize_gpr();
    for (int i = 0; i < 24; i++) begin
      if (pick(5) == 0) begin
        add_byte(8'h83);
        add_modrm(3'd0, i % 3);
        add_byte(rand_byte());
      end else begin
        add_byte(alu_op(pick(4)));
        add_modrm(3'(pick(8)), i % 3);
      end
      send_instr();
    end
    close_test("memory forms");

    randomize_gpr();
    send_bytes(32'h00c1_af0f, 3);
    send_bytes(32'h1046_af0f, 4);
    send_bytes(32'h0000_0043, 1);
    send_bytes(32'h0000_004f, 1);
    send_bytes(32'h0000_0090, 1);
    send_bytes(32'h0000_9066, 2);
    send_bytes(32'h00c0_010f, 3);
    send_bytes(32'h0024_048b, 3);
    send_bytes(32'h0000_058b, 2);
    send_bytes(32'h0005_c883, 3);
    send_bytes(32'h00c1_8b67, 3);
    send_bytes(32'h9066_6666, 4);
    send_bytes(32'h0000_90f3, 2);
    close_test("escape, INC, NOP and invalid");

    ack_delay = 20;
    repeat (6) send_random();
    close_test("back-pressure");

    random_ack = 1'b1;
    for (int n = 0; n < 200; n++) begin
      if (n % 25 == 0) begin
        wait_idle();
        randomize_gpr();
      end
      send_random();
    end
    close_test("random mix");

    $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb.f
x86_dec_pkg.sv
decode_prefix.sv
decode_opcode.sv
decode_opnds.sv
decode.sv
decode_checker.sv
tb_decode.sv

//--- Bender.yml
package:
  name: x86_decode

sources:
  - x86_dec_pkg.sv
  - decode_prefix.sv
  - decode_opcode.sv
  - decode_opnds.sv
  - decode.sv
  - target: test
    files:
      - decode_checker.sv
      - tb_decode.sv
